//--- logic/pwo_consts.svh
//==========================================================
// Widths, modulus and polynomial size for the PWO engine
// Include wherever ports or arithmetic are sized from them
//==========================================================

`ifndef PWO_CONSTS_SVH
`define PWO_CONSTS_SVH

// ML-DSA modulus, q = 2^23 - 2^13 + 1
`define PWO_Q       23'd8380417

// One coefficient and the lane that carries it in a memory word
`define PWO_COEF_W  23
`define PWO_LANE_W  24
`define PWO_LANES   4

// Memory addressing
`define PWO_ADDR_W  15

// 256 coefficients at four per word
`define PWO_WORDS   64
`define PWO_CNT_W   6

`endif

//--- logic/pwo_mem_pkg.sv
//==========================================================
// Memory-side types: request opcode, request and data word
//==========================================================

`default_nettype none

`include "pwo_consts.svh"

package pwo_mem_pkg;

    // Request opcode on every memory port
    typedef enum logic [1:0] {
        idle  = 2'b00,
        read  = 2'b01,
        write = 2'b10
    } rw_op_t;

    typedef struct packed {
        rw_op_t                 rd_wr_en;
        logic [`PWO_ADDR_W-1:0] addr;
    } mem_req_t;

    // Pad bit sits above the coefficient and is always written as zero
    typedef struct packed {
        logic [`PWO_LANE_W-`PWO_COEF_W-1:0] pad;
        logic [`PWO_COEF_W-1:0]             coef;
    } pwo_lane_t;

    // Lane 0 in the low bits
    typedef pwo_lane_t [`PWO_LANES-1:0] pwo_word_t;

endpackage

`default_nettype wire

//--- logic/pwo_ctrl_pkg.sv
//==========================================================
// Control-side types: mode, base addresses, configuration
// and the tag that follows each issued word
//==========================================================

`default_nettype none

`include "pwo_consts.svh"

package pwo_ctrl_pkg;

    typedef enum logic [1:0] {
        pwm = 2'b00,
        pwa = 2'b01,
        pws = 2'b10
    } pwo_mode_t;

    typedef struct packed {
        logic [`PWO_ADDR_W-1:0] a_base;
        logic [`PWO_ADDR_W-1:0] b_base;
        logic [`PWO_ADDR_W-1:0] c_base;
    } pwo_base_t;

    typedef struct packed {
        pwo_mode_t mode;
        logic      accumulate;
        pwo_base_t base;
    } pwo_cfg_t;

    // Travels with a read so the write side needs no address math
    typedef struct packed {
        logic                   valid;
        logic                   last;
        logic [`PWO_ADDR_W-1:0] wr_addr;
    } pwo_tag_t;

endpackage

`default_nettype wire

//--- logic/pwo_lane_alu.sv
//==========================================================
// One coefficient lane: modular add, subtract, multiply and
// multiply-accumulate; inputs are expected below q
//==========================================================

`default_nettype none

`include "pwo_consts.svh"

module pwo_lane_alu (
    input  pwo_ctrl_pkg::pwo_mode_t mode_i,
    input  logic                    accumulate_i,
    input  pwo_mem_pkg::pwo_lane_t  a_i,
    input  pwo_mem_pkg::pwo_lane_t  b_i,
    input  pwo_mem_pkg::pwo_lane_t  c_i,
    output pwo_mem_pkg::pwo_lane_t  res_o
);

    localparam int CW = `PWO_COEF_W;
    localparam int PW = 2 * CW;
    // q = 2^23 - 2^13 + 1, so 2^23 folds to 2^13 - 1
    localparam int Q_SHIFT = 13;

    // One fold of the high part back into the low 23 bits
    function automatic logic [PW-1:0] fold(input logic [PW-1:0] x);
        logic [PW-1:0] hi;
        logic [PW-1:0] lo;
        hi = x >> CW;
        lo = PW'(x[CW-1:0]);
        return lo + (hi << Q_SHIFT) - hi;
    endfunction

    logic [PW-1:0] prod;
    logic [PW-1:0] r1;
    logic [PW-1:0] r2;
    logic [PW-1:0] r3;
    logic [PW-1:0] r3_sub;
    logic [CW-1:0] prod_mod;
    logic [CW-1:0] add_x;
    logic [CW-1:0] add_y;
    logic [CW:0]   sum;
    logic [CW-1:0] sum_fix;
    logic [CW:0]   diff;
    logic [CW-1:0] diff_fix;
    logic          is_pwm;

    assign is_pwm = (mode_i == pwo_ctrl_pkg::pwm);

    // Three folds bring the 46-bit product below 2q
    assign prod     = PW'(a_i.coef) * PW'(b_i.coef);
    assign r1       = fold(prod);
    assign r2       = fold(r1);
    assign r3       = fold(r2);
    assign r3_sub   = r3 - `PWO_Q;
    assign prod_mod = (r3 >= `PWO_Q) ? r3_sub[CW-1:0] : r3[CW-1:0];

    // Shared adder: a + b for pwa, product + old c for accumulate
    assign add_x   = is_pwm ? prod_mod : a_i.coef;
    assign add_y   = is_pwm ? (accumulate_i ? c_i.coef : '0) : b_i.coef;
    assign sum     = {1'b0, add_x} + {1'b0, add_y};
    assign sum_fix = (sum >= `PWO_Q) ? (sum[CW-1:0] - `PWO_Q) : sum[CW-1:0];

    // Borrow out of the top bit means a < b
    assign diff     = {1'b0, a_i.coef} - {1'b0, b_i.coef};
    assign diff_fix = diff[CW] ? (diff[CW-1:0] + `PWO_Q) : diff[CW-1:0];

    always_comb begin
        res_o.pad = '0;
        if (mode_i == pwo_ctrl_pkg::pws) begin
            res_o.coef = diff_fix;
        end else begin
            res_o.coef = sum_fix;
        end
    end

endmodule

`default_nettype wire

//--- logic/pwo_cfg_regs.sv
//==========================================================
// Four-phase req/ack handshake and configuration latch;
// issues the start pulse and holds cfg for the whole run
//==========================================================

`default_nettype none

module pwo_cfg_regs (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize_i,
    input  logic                   req_i,
    input  pwo_ctrl_pkg::pwo_cfg_t cfg_i,
    input  logic                   last_wr_i,
    output pwo_ctrl_pkg::pwo_cfg_t cfg_o,
    output logic                   start_o,
    output logic                   busy_o,
    output logic                   ack_o
);

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_ack
    } state_t;

    state_t                 state;
    state_t                 state_nxt;
    pwo_ctrl_pkg::pwo_cfg_t cfg_q;
    logic                   start_q;
    logic                   accept;

    // req is only taken in idle, where ack is low
    assign accept = (state == st_idle) && req_i;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: if (req_i) state_nxt = st_busy;
            st_busy: if (last_wr_i) state_nxt = st_ack;
            // Ack held until the host releases req
            st_ack:  if (!req_i) state_nxt = st_idle;
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= st_idle;
            start_q <= 1'b0;
            cfg_q   <= '0;
        end else if (zeroize_i) begin
            state   <= st_idle;
            start_q <= 1'b0;
            cfg_q   <= '0;
        end else begin
            state   <= state_nxt;
            start_q <= accept;
            if (accept) cfg_q <= cfg_i;
        end
    end

    assign cfg_o   = cfg_q;
    assign start_o = start_q;
    assign busy_o  = (state == st_busy);
    assign ack_o   = (state == st_ack);

endmodule

`default_nettype wire

//--- logic/pwo_addr_gen.sv
//==========================================================
// Word counter for the operand reads; issues only while the
// sampler has data and tags each issue with its write slot
//==========================================================

`default_nettype none

`include "pwo_consts.svh"

module pwo_addr_gen (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize_i,
    input  logic                   start_i,
    input  pwo_ctrl_pkg::pwo_cfg_t cfg_i,
    input  logic                   sampler_valid_i,
    output pwo_mem_pkg::mem_req_t  a_rd_req_o,
    output pwo_mem_pkg::mem_req_t  b_rd_req_o,
    output pwo_mem_pkg::mem_req_t  c_rd_req_o,
    output pwo_ctrl_pkg::pwo_tag_t tag_o
);

    logic                   active;
    logic [`PWO_CNT_W-1:0]  count;
    logic [`PWO_ADDR_W-1:0] offset;
    logic                   issue;
    logic                   last_word;
    logic                   read_c;

    assign issue     = active && sampler_valid_i;
    assign last_word = (count == (`PWO_WORDS - 1));
    assign offset    = {{(`PWO_ADDR_W - `PWO_CNT_W){1'b0}}, count};

    // Old c is only needed when accumulating a product
    assign read_c = (cfg_i.mode == pwo_ctrl_pkg::pwm) && cfg_i.accumulate;

    // Count holds on a stalled cycle and wraps to 0 after word 63
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            active <= 1'b0;
            count  <= '0;
        end else if (zeroize_i) begin
            active <= 1'b0;
            count  <= '0;
        end else if (start_i) begin
            active <= 1'b1;
            count  <= '0;
        end else if (issue) begin
            count <= count + 1'b1;
            if (last_word) active <= 1'b0;
        end
    end

    always_comb begin
        a_rd_req_o.rd_wr_en = issue ? pwo_mem_pkg::read : pwo_mem_pkg::idle;
        a_rd_req_o.addr     = cfg_i.base.a_base + offset;
        b_rd_req_o.rd_wr_en = issue ? pwo_mem_pkg::read : pwo_mem_pkg::idle;
        b_rd_req_o.addr     = cfg_i.base.b_base + offset;
        c_rd_req_o.rd_wr_en = (issue && read_c) ? pwo_mem_pkg::read : pwo_mem_pkg::idle;
        c_rd_req_o.addr     = cfg_i.base.c_base + offset;

        tag_o.valid   = issue;
        tag_o.last    = issue && last_word;
        tag_o.wr_addr = cfg_i.base.c_base + offset;
    end

endmodule

`default_nettype wire

//--- logic/pwo_datapath.sv
//==========================================================
// Two-stage pointwise pipeline: the tag waits one cycle for
// the memory data, then four lanes feed a registered write
//==========================================================

`default_nettype none

`include "pwo_consts.svh"

module pwo_datapath (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize_i,
    input  pwo_ctrl_pkg::pwo_cfg_t cfg_i,
    input  pwo_ctrl_pkg::pwo_tag_t tag_i,
    input  pwo_mem_pkg::pwo_word_t a_rd_data_i,
    input  pwo_mem_pkg::pwo_word_t b_rd_data_i,
    input  pwo_mem_pkg::pwo_word_t c_rd_data_i,
    output pwo_mem_pkg::mem_req_t  wr_req_o,
    output pwo_mem_pkg::pwo_word_t wr_data_o,
    output logic                   last_wr_o
);

    pwo_ctrl_pkg::pwo_tag_t tag_q;
    pwo_mem_pkg::pwo_word_t res_word;
    pwo_mem_pkg::mem_req_t  wr_req_q;
    pwo_mem_pkg::pwo_word_t wr_data_q;
    logic                   last_q;

    //==========================================================
    // Stage 1: tag lines up with the returned read data
    //==========================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tag_q <= '0;
        end else if (zeroize_i) begin
            tag_q <= '0;
        end else begin
            tag_q <= tag_i;
        end
    end

    for (genvar i = 0; i < `PWO_LANES; i++) begin : g_lane
        pwo_lane_alu pwo_lane_alu_i (
            .mode_i       (cfg_i.mode),
            .accumulate_i (cfg_i.accumulate),
            .a_i          (a_rd_data_i[i]),
            .b_i          (b_rd_data_i[i]),
            .c_i          (c_rd_data_i[i]),
            .res_o        (res_word[i])
        );
    end

    //==========================================================
    // Stage 2: write request, result word and last pulse
    //==========================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_req_q.rd_wr_en <= pwo_mem_pkg::idle;
            wr_req_q.addr     <= '0;
            last_q            <= 1'b0;
        end else if (zeroize_i) begin
            wr_req_q.rd_wr_en <= pwo_mem_pkg::idle;
            wr_req_q.addr     <= '0;
            last_q            <= 1'b0;
        end else begin
            wr_req_q.rd_wr_en <= tag_q.valid ? pwo_mem_pkg::write : pwo_mem_pkg::idle;
            wr_req_q.addr     <= tag_q.wr_addr;
            last_q            <= tag_q.valid && tag_q.last;
        end
    end

    // Result word only loads on a valid item; pad bits forced to zero
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            wr_data_q <= '0;
        end else if (tag_q.valid) begin
            for (int i = 0; i < `PWO_LANES; i++) begin
                wr_data_q[i].pad  <= '0;
                wr_data_q[i].coef <= res_word[i].coef;
            end
        end
    end

    assign wr_req_o  = wr_req_q;
    assign wr_data_o = wr_data_q;
    assign last_wr_o = last_q;

endmodule

`default_nettype wire

//--- logic/pwo_top.sv
//==========================================================
// PWO engine top: pointwise add, subtract and multiply on
// one polynomial, started by a four-phase req/ack handshake
//==========================================================

`default_nettype none

module pwo_top (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize_i,
    input  logic                   req_i,
    input  pwo_ctrl_pkg::pwo_cfg_t cfg_i,
    input  logic                   sampler_valid_i,
    input  pwo_mem_pkg::pwo_word_t a_rd_data_i,
    input  pwo_mem_pkg::pwo_word_t b_rd_data_i,
    input  pwo_mem_pkg::pwo_word_t c_rd_data_i,
    output logic                   ack_o,
    output logic                   busy_o,
    output pwo_mem_pkg::mem_req_t  a_rd_req_o,
    output pwo_mem_pkg::mem_req_t  b_rd_req_o,
    output pwo_mem_pkg::mem_req_t  c_rd_req_o,
    output pwo_mem_pkg::mem_req_t  wr_req_o,
    output pwo_mem_pkg::pwo_word_t wr_data_o
);

    pwo_ctrl_pkg::pwo_cfg_t cfg;
    pwo_ctrl_pkg::pwo_tag_t tag;
    logic                   start;
    logic                   last_wr;

    pwo_cfg_regs pwo_cfg_regs_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .req_i     (req_i),
        .cfg_i     (cfg_i),
        .last_wr_i (last_wr),
        .cfg_o     (cfg),
        .start_o   (start),
        .busy_o    (busy_o),
        .ack_o     (ack_o)
    );

    pwo_addr_gen pwo_addr_gen_i (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize_i       (zeroize_i),
        .start_i         (start),
        .cfg_i           (cfg),
        .sampler_valid_i (sampler_valid_i),
        .a_rd_req_o      (a_rd_req_o),
        .b_rd_req_o      (b_rd_req_o),
        .c_rd_req_o      (c_rd_req_o),
        .tag_o           (tag)
    );

    pwo_datapath pwo_datapath_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .cfg_i       (cfg),
        .tag_i       (tag),
        .a_rd_data_i (a_rd_data_i),
        .b_rd_data_i (b_rd_data_i),
        .c_rd_data_i (c_rd_data_i),
        .wr_req_o    (wr_req_o),
        .wr_data_o   (wr_data_o),
        .last_wr_o   (last_wr)
    );

endmodule

`default_nettype wire

//--- verification/pwo_checker.sv
//==========================================================
// Concurrent checks on the handshake and memory requests,
// bound into the PWO top level
//==========================================================

`default_nettype none

module pwo_checker (
    input logic                  clk,
    input logic                  reset_n,
    input logic                  zeroize_i,
    input logic                  req_i,
    input logic                  ack_i,
    input logic                  busy_i,
    input logic                  sampler_valid_i,
    input pwo_mem_pkg::mem_req_t b_rd_req_i,
    input pwo_mem_pkg::mem_req_t wr_req_i
);

    int assert_fail_count = 0;

    // Writes belong to an accepted operation
    wr_only_when_busy: assert property (@(posedge clk) disable iff (!reset_n)
        (wr_req_i.rd_wr_en == pwo_mem_pkg::write) |-> busy_i)
        else begin
            assert_fail_count++;
            $error("write request while the engine is not busy");
        end

    // Ack is held until the host releases req
    ack_held_for_req: assert property (@(posedge clk) disable iff (!reset_n)
        ($fell(ack_i) && !$past(zeroize_i)) |-> !$past(req_i))
        else begin
            assert_fail_count++;
            $error("ack dropped while req was still high");
        end

    no_b_read_on_stall: assert property (@(posedge clk) disable iff (!reset_n)
        !sampler_valid_i |-> (b_rd_req_i.rd_wr_en == pwo_mem_pkg::idle))
        else begin
            assert_fail_count++;
            $error("b read issued without valid sampler data");
        end

endmodule

bind pwo_top pwo_checker pwo_checker_i (
    .clk             (clk),
    .reset_n         (reset_n),
    .zeroize_i       (zeroize_i),
    .req_i           (req_i),
    .ack_i           (ack_o),
    .busy_i          (busy_o),
    .sampler_valid_i (sampler_valid_i),
    .b_rd_req_i      (b_rd_req_o),
    .wr_req_i        (wr_req_o)
);

`default_nettype wire

//--- verification/pwo_tb.sv
//==========================================================
// Directed testbench for the PWO engine with memory models,
// one task per test, compare tasks and a watchdog
//==========================================================

`default_nettype none

`include "pwo_consts.svh"

module pwo_tb;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 10;
    localparam int NUM_TESTS     = 6;
    localparam int WATCHDOG_TIME = 2 * NUM_TESTS * `PWO_WORDS * 4 * CLK_PERIOD;
    localparam int ACK_LIMIT     = 8 * `PWO_WORDS;
    localparam int ADDR_W        = `PWO_ADDR_W;
    localparam int MEM_DEPTH     = 1 << `PWO_ADDR_W;
    localparam pwo_mem_pkg::mem_req_t IDLE_REQ = '{rd_wr_en: pwo_mem_pkg::idle, addr: '0};

    logic                   clk = 1'b0;
    logic                   reset_n;
    logic                   zeroize_i;
    logic                   req_i;
    pwo_ctrl_pkg::pwo_cfg_t cfg_i;
    logic                   sampler_valid_i = 1'b0;
    pwo_mem_pkg::pwo_word_t a_rd_data_i = '0;
    pwo_mem_pkg::pwo_word_t b_rd_data_i = '0;
    pwo_mem_pkg::pwo_word_t c_rd_data_i = '0;
    logic                   ack_o;
    logic                   busy_o;
    pwo_mem_pkg::mem_req_t  a_rd_req_o;
    pwo_mem_pkg::mem_req_t  b_rd_req_o;
    pwo_mem_pkg::mem_req_t  c_rd_req_o;
    pwo_mem_pkg::mem_req_t  wr_req_o;
    pwo_mem_pkg::pwo_word_t wr_data_o;

    // Memory models and the words expected at c_base onwards
    pwo_mem_pkg::pwo_word_t a_mem [MEM_DEPTH];
    pwo_mem_pkg::pwo_word_t b_mem [MEM_DEPTH];
    pwo_mem_pkg::pwo_word_t c_mem [MEM_DEPTH];
    pwo_mem_pkg::pwo_word_t exp_words [`PWO_WORDS];
    logic [ADDR_W-1:0]      exp_c_base = '0;
    logic                   c_must_idle = 1'b1;
    logic                   stall_en = 1'b0;
    int                     wr_count = 0;
    int                     check_count = 0;
    int                     mismatch_count = 0;
    int                     fail_count = 0;

    pwo_top pwo_top_i (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize_i       (zeroize_i),
        .req_i           (req_i),
        .cfg_i           (cfg_i),
        .sampler_valid_i (sampler_valid_i),
        .a_rd_data_i     (a_rd_data_i),
        .b_rd_data_i     (b_rd_data_i),
        .c_rd_data_i     (c_rd_data_i),
        .ack_o           (ack_o),
        .busy_o          (busy_o),
        .a_rd_req_o      (a_rd_req_o),
        .b_rd_req_o      (b_rd_req_o),
        .c_rd_req_o      (c_rd_req_o),
        .wr_req_o        (wr_req_o),
        .wr_data_o       (wr_data_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Sampler has data about three cycles in four while stalling
    always @(posedge clk) begin
        sampler_valid_i <= stall_en ? (($urandom % 4) != 0) : 1'b1;
    end

    //==========================================================
    // Memory models with one cycle of read latency, and the
    // write monitor
    //==========================================================
    always @(posedge clk) begin : mem_model
        pwo_mem_pkg::mem_req_t want_req;
        if (a_rd_req_o.rd_wr_en == pwo_mem_pkg::read) a_rd_data_i <= a_mem[a_rd_req_o.addr];
        if (b_rd_req_o.rd_wr_en == pwo_mem_pkg::read) b_rd_data_i <= b_mem[b_rd_req_o.addr];
        if (c_rd_req_o.rd_wr_en == pwo_mem_pkg::read) c_rd_data_i <= c_mem[c_rd_req_o.addr];
        if (c_must_idle) check_req(c_rd_req_o, IDLE_REQ, "c read request");
        if (wr_req_o.rd_wr_en == pwo_mem_pkg::write) begin
            if (wr_count < `PWO_WORDS) begin
                want_req.rd_wr_en = pwo_mem_pkg::write;
                want_req.addr     = exp_c_base + ADDR_W'(wr_count);
                check_req(wr_req_o, want_req, "write request");
                check_word(wr_data_o, exp_words[wr_count], "write data");
            end else begin
                note_failure("write request after the last word of the polynomial");
            end
            c_mem[wr_req_o.addr] <= wr_data_o;
            wr_count++;
        end
    end

    task automatic check_word(input pwo_mem_pkg::pwo_word_t got,
                              input pwo_mem_pkg::pwo_word_t want, input string what);
        check_count++;
        if (got !== want) begin
            mismatch_count++;
            $display("mismatch at %0t: %s got %h, expected %h", $time, what, got, want);
        end
    endtask

    // Address only matters when the request is not idle
    task automatic check_req(input pwo_mem_pkg::mem_req_t got,
                             input pwo_mem_pkg::mem_req_t want, input string what);
        check_count++;
        if ((got.rd_wr_en !== want.rd_wr_en) ||
            ((want.rd_wr_en != pwo_mem_pkg::idle) && (got.addr !== want.addr))) begin
            mismatch_count++;
            $display("mismatch at %0t: %s got %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic note_failure(input string msg);
        fail_count++;
        $display("%s (time %0t)", msg, $time);
    endtask

    task automatic check_idle(input string when_txt);
        check_req(a_rd_req_o, IDLE_REQ, {"a read request ", when_txt});
        check_req(b_rd_req_o, IDLE_REQ, {"b read request ", when_txt});
        check_req(c_rd_req_o, IDLE_REQ, {"c read request ", when_txt});
        check_req(wr_req_o, IDLE_REQ, {"write request ", when_txt});
        if (ack_o !== 1'b0 || busy_o !== 1'b0) note_failure({"ack or busy not low ", when_txt});
    endtask

    function automatic logic [`PWO_COEF_W-1:0] rand_coef();
        return `PWO_COEF_W'($urandom % 32'(`PWO_Q));
    endfunction

    // One coefficient from the modular rules of each mode
    function automatic logic [`PWO_COEF_W-1:0] ref_coef(
        input pwo_ctrl_pkg::pwo_mode_t mode, input logic acc,
        input logic [`PWO_COEF_W-1:0] a, input logic [`PWO_COEF_W-1:0] b,
        input logic [`PWO_COEF_W-1:0] c
    );
        longint unsigned q;
        longint unsigned r;
        q = `PWO_Q;
        case (mode)
            pwo_ctrl_pkg::pwa: r = (longint'(a) + longint'(b)) % q;
            pwo_ctrl_pkg::pws: r = (longint'(a) + q - longint'(b)) % q;
            default: begin
                r = (longint'(a) * longint'(b)) % q;
                if (acc) r = (r + longint'(c)) % q;
            end
        endcase
        return r[`PWO_COEF_W-1:0];
    endfunction

    function automatic pwo_ctrl_pkg::pwo_cfg_t make_cfg(
        input pwo_ctrl_pkg::pwo_mode_t mode, input logic acc,
        input logic [ADDR_W-1:0] a_base, input logic [ADDR_W-1:0] b_base,
        input logic [ADDR_W-1:0] c_base
    );
        return '{mode: mode, accumulate: acc,
                 base: '{a_base: a_base, b_base: b_base, c_base: c_base}};
    endfunction

    task automatic fill_operands(input pwo_ctrl_pkg::pwo_cfg_t cfg, input logic a_below_b);
        pwo_mem_pkg::pwo_word_t wa;
        pwo_mem_pkg::pwo_word_t wb;
        pwo_mem_pkg::pwo_word_t wc;
        logic [`PWO_COEF_W-1:0] t;
        for (int i = 0; i < `PWO_WORDS; i++) begin
            for (int l = 0; l < `PWO_LANES; l++) begin
                wa[l] = '{pad: '0, coef: rand_coef()};
                wb[l] = '{pad: '0, coef: rand_coef()};
                wc[l] = '{pad: '0, coef: rand_coef()};
                // Even lanes get a below b so the difference wraps
                if (a_below_b && (l % 2 == 0) && (wa[l].coef > wb[l].coef)) begin
                    t          = wa[l].coef;
                    wa[l].coef = wb[l].coef;
                    wb[l].coef = t;
                end
                exp_words[i][l].pad  = '0;
                exp_words[i][l].coef = ref_coef(cfg.mode, cfg.accumulate,
                                                wa[l].coef, wb[l].coef, wc[l].coef);
            end
            a_mem[cfg.base.a_base + ADDR_W'(i)] = wa;
            b_mem[cfg.base.b_base + ADDR_W'(i)] = wb;
            c_mem[cfg.base.c_base + ADDR_W'(i)] = wc;
        end
    endtask

    // Full four-phase handshake around one operation
    task automatic run_op(input pwo_ctrl_pkg::pwo_cfg_t cfg, input logic a_below_b,
                          input logic stall);
        int cycles;
        fill_operands(cfg, a_below_b);
        wr_count    = 0;
        exp_c_base  = cfg.base.c_base;
        c_must_idle = !((cfg.mode == pwo_ctrl_pkg::pwm) && cfg.accumulate);
        stall_en   <= stall;
        @(posedge clk);
        cfg_i <= cfg;
        req_i <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!ack_o && cycles < ACK_LIMIT);
        if (!ack_o) begin
            note_failure("no ack from the DUT within the time limit");
        end else begin
            if (busy_o) note_failure("busy still high while ack is high");
            if (wr_count != `PWO_WORDS) note_failure($sformatf("%0d writes, not 64", wr_count));
        end
        stall_en <= 1'b0;
        req_i <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while ((ack_o || busy_o) && cycles < 4);
        if (ack_o || busy_o) note_failure("ack or busy still high after req was released");
        c_must_idle = 1'b1;
    endtask

    //==========================================================
    // Directed tests
    //==========================================================
    task automatic test_reset_zeroize();
        pwo_ctrl_pkg::pwo_cfg_t cfg;
        cfg = make_cfg(pwo_ctrl_pkg::pwa, 1'b0, 15'h0000, 15'h0040, 15'h0080);
        @(posedge clk);
        check_idle("after reset");
        fill_operands(cfg, 1'b0);
        wr_count   = 0;
        exp_c_base = cfg.base.c_base;
        cfg_i <= cfg;
        req_i <= 1'b1;
        // Stop partway with reads and writes in flight
        repeat (20) @(posedge clk);
        if (!busy_o) note_failure("engine not busy before zeroize");
        zeroize_i <= 1'b1;
        req_i     <= 1'b0;
        @(posedge clk);
        zeroize_i <= 1'b0;
        @(posedge clk);
        check_idle("after zeroize");
    endtask

    task automatic test_pwa();
        run_op(make_cfg(pwo_ctrl_pkg::pwa, 1'b0, 15'h0100, 15'h0400, 15'h7fc0), 1'b0, 1'b0);
    endtask

    task automatic test_pws_wrap();
        run_op(make_cfg(pwo_ctrl_pkg::pws, 1'b0, 15'h1000, 15'h2000, 15'h3000), 1'b1, 1'b0);
    endtask

    task automatic test_pwm();
        run_op(make_cfg(pwo_ctrl_pkg::pwm, 1'b0, 15'h0200, 15'h0300, 15'h0500), 1'b0, 1'b0);
    endtask

    task automatic test_pwm_acc();
        run_op(make_cfg(pwo_ctrl_pkg::pwm, 1'b1, 15'h4000, 15'h5000, 15'h6000), 1'b0, 1'b0);
    endtask

    task automatic test_pwm_stall();
        run_op(make_cfg(pwo_ctrl_pkg::pwm, 1'b0, 15'h0000, 15'h0040, 15'h0080), 1'b0, 1'b1);
    endtask

    initial begin
        void'($urandom(32'ha2de_81c8));
        reset_n   = 1'b0;
        zeroize_i = 1'b0;
        req_i     = 1'b0;
        cfg_i     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
        test_reset_zeroize();
        test_pwa();
        test_pws_wrap();
        test_pwm();
        test_pwm_acc();
        test_pwm_stall();
        $display("checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                 check_count, mismatch_count, fail_count,
                 pwo_top_i.pwo_checker_i.assert_fail_count);
        if (mismatch_count + fail_count + pwo_top_i.pwo_checker_i.assert_fail_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired after %0d time units, tests did not finish", WATCHDOG_TIME);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+logic
logic/pwo_mem_pkg.sv
logic/pwo_ctrl_pkg.sv
logic/pwo_lane_alu.sv
logic/pwo_cfg_regs.sv
logic/pwo_addr_gen.sv
logic/pwo_datapath.sv
logic/pwo_top.sv
verification/pwo_checker.sv
verification/pwo_tb.sv

//--- Makefile
# Verilator build and run of the PWO engine testbench

SIM_LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build pwo_tb with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module pwo_tb -Mdir obj_dir
	./obj_dir/Vpwo_tb > $(SIM_LOG) 2>&1; cat $(SIM_LOG)
	@if grep -qx "No errors" $(SIM_LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(SIM_LOG)
